// File: src.f
verilog/pipe_pkg.sv
verilog/register_file.sv
verilog/stage_register.sv
verilog/execute_stage.sv
verilog/pipe_core.sv
sim/pipe_core_tb.sv

// File: Makefile
# Verilator build and run for the pipeline testbench

VERILATOR ?= verilator
TOP       ?= pipe_core_tb
FILE_LIST ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= all tests passed

SOURCES := $(shell cat $(FILE_LIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/pipe_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_core_tb;

    localparam int num_regs = 8;
    localparam int total_instr = 8 + 24 + 40 + 50 + 300;
    // twenty cycles per instruction plus reset and some slack
    localparam int watchdog_cycles = total_instr * 20 + 16 + 200;

    typedef struct packed
    {
        pipe_pkg::op_t                      op;
        logic [pipe_pkg::reg_num_width-1:0] dst_num;
        logic [pipe_pkg::reg_num_width-1:0] src_1_num;
        logic [pipe_pkg::reg_num_width-1:0] src_2_num;
        logic [pipe_pkg::data_width-1:0]    imm;
    } instr_t;

    typedef struct packed
    {
        logic [pipe_pkg::reg_num_width-1:0] dst_num;
        logic [pipe_pkg::data_width-1:0]    result;
        int                                 cycle;
    } expect_t;

    logic                               clk;
    logic                               reset;
    logic                               in_valid;
    logic                               in_ready;
    pipe_pkg::op_t                      in_op;
    logic [pipe_pkg::reg_num_width-1:0] in_dst_num;
    logic [pipe_pkg::reg_num_width-1:0] in_src_1_num;
    logic [pipe_pkg::reg_num_width-1:0] in_src_2_num;
    logic [pipe_pkg::data_width-1:0]    in_imm;
    logic                               out_valid;
    logic                               out_ready;
    logic [pipe_pkg::reg_num_width-1:0] out_dst_num;
    logic [pipe_pkg::data_width-1:0]    out_result;

    int seed = 32'hbc4c;
    // reference register file updated in program order at acceptance
    logic [pipe_pkg::data_width-1:0] model_regs [num_regs];
    instr_t  program_q [$];
    expect_t expect_q [$];
    instr_t  cur_instr;
    string   test_name;
    bit      in_fired;
    bit      check_latency;
    int      cycle_count;
    int      gap_pct;
    int      ready_pct;
    int      test_checks;
    int      test_errors;
    int      total_checks;
    int      total_errors;
    int      tests_run;

    pipe_core #(.num_regs(num_regs)) u_pipe_core
    (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_op        (in_op),
        .in_dst_num   (in_dst_num),
        .in_src_1_num (in_src_1_num),
        .in_src_2_num (in_src_2_num),
        .in_imm       (in_imm),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_dst_num  (out_dst_num),
        .out_result   (out_result)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        #(watchdog_cycles * 10);
        $display("watchdog expired after %0d cycles, results stopped arriving", watchdog_cycles);
        $display("tests failed");
        $finish;
    end

    function automatic int unsigned rand_below(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // operation semantics as the instruction set defines them
    function automatic logic [15:0] model_result(pipe_pkg::op_t op, logic [15:0] a,
                                                 logic [15:0] b, logic [15:0] imm);
        case (op)
            pipe_pkg::op_add: return a + b;
            pipe_pkg::op_sub: return a - b;
            pipe_pkg::op_and: return a & b;
            pipe_pkg::op_or:  return a | b;
            pipe_pkg::op_xor: return a ^ b;
            pipe_pkg::op_shl: return a << b[3:0];
            pipe_pkg::op_shr: return a >> b[3:0];
            pipe_pkg::op_li:  return imm;
            default:          return '0;
        endcase
    endfunction

    function automatic instr_t make_instr(pipe_pkg::op_t op, int dst, int src_1, int src_2,
                                          logic [15:0] imm);
        instr_t ins;
        ins.op        = op;
        ins.dst_num   = 3'(dst);
        ins.src_1_num = 3'(src_1);
        ins.src_2_num = 3'(src_2);
        ins.imm       = imm;
        return ins;
    endfunction

    function automatic instr_t random_instr();
        return make_instr(pipe_pkg::op_t'(3'(rand_below(8))), int'(rand_below(8)),
                          int'(rand_below(8)), int'(rand_below(8)), 16'($random(seed)));
    endfunction

    task automatic accept_instr();
        logic [15:0] result;
        expect_t     entry;
        result = model_result(cur_instr.op, model_regs[cur_instr.src_1_num],
                              model_regs[cur_instr.src_2_num], cur_instr.imm);
        model_regs[cur_instr.dst_num] = result;
        entry.dst_num = cur_instr.dst_num;
        entry.result  = result;
        entry.cycle   = cycle_count;
        expect_q.push_back(entry);
        in_fired = 1'b1;
    endtask

    task automatic check_result();
        expect_t exp;
        test_checks++;
        assert (expect_q.size() > 0)
        else
        begin
            $display("%s: result for r%0d arrived with no instruction outstanding",
                     test_name, out_dst_num);
            test_errors++;
        end
        if (expect_q.size() > 0)
        begin
            exp = expect_q.pop_front();
            assert (out_dst_num == exp.dst_num && out_result == exp.result)
            else
            begin
                $display("MISMATCH %s expected r%0d=%h actual r%0d=%h", test_name,
                         exp.dst_num, exp.result, out_dst_num, out_result);
                test_errors++;
            end
            if (check_latency)
            begin
                assert (cycle_count - exp.cycle == 2)
                else
                begin
                    $display("MISMATCH %s latency expected 2 actual %0d", test_name,
                             cycle_count - exp.cycle);
                    test_errors++;
                end
            end
        end
    endtask

    // drive after the falling edge and look at what transfers at the rising one
    task automatic run_cycle();
        @(negedge clk);
        if (in_fired)
        begin
            in_valid = 1'b0;
            in_fired = 1'b0;
        end
        out_ready = rand_below(100) < ready_pct;
        if (!in_valid && program_q.size() > 0 && rand_below(100) >= gap_pct)
        begin
            cur_instr    = program_q.pop_front();
            in_valid     = 1'b1;
            in_op        = cur_instr.op;
            in_dst_num   = cur_instr.dst_num;
            in_src_1_num = cur_instr.src_1_num;
            in_src_2_num = cur_instr.src_2_num;
            in_imm       = cur_instr.imm;
        end
        #1;
        if (out_valid && out_ready)
            check_result();
        if (in_valid && in_ready)
            accept_instr();
        cycle_count++;
    endtask

    task automatic start_test(string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic finish_test();
        while (program_q.size() > 0 || (in_valid && !in_fired) || expect_q.size() > 0)
            run_cycle();
        // a few idle cycles to catch stray results
        repeat (4) run_cycle();
        $display("%s: %0d results checked, %0d errors", test_name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        tests_run++;
    endtask

    initial
    begin
        instr_t ins;
        int     ra;
        int     rb;
        int     prev_1;
        int     prev_2;
        reset        = 1'b0;
        in_valid     = 1'b0;
        in_op        = pipe_pkg::op_add;
        in_dst_num   = '0;
        in_src_1_num = '0;
        in_src_2_num = '0;
        in_imm       = '0;
        out_ready    = 1'b0;
        in_fired     = 1'b0;
        cycle_count  = 0;
        gap_pct      = 0;
        ready_pct    = 100;
        check_latency = 1'b0;
        for (int i = 0; i < num_regs; i++)
            model_regs[i] = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
        #1;

        start_test("reset");
        test_checks += 2;
        assert (out_valid == 1'b0)
        else
        begin
            $display("MISMATCH %s out_valid expected 0 actual %b", test_name, out_valid);
            test_errors++;
        end
        assert (in_ready == 1'b1)
        else
        begin
            $display("MISMATCH %s in_ready expected 1 actual %b", test_name, in_ready);
            test_errors++;
        end
        for (int i = 0; i < num_regs; i++)
            program_q.push_back(make_instr(pipe_pkg::op_add, i, i, i, 16'h0));
        finish_test();

        start_test("alu_ops");
        for (int k = 0; k < 8; k++)
        begin
            ra = int'(rand_below(8));
            rb = int'(rand_below(8));
            program_q.push_back(make_instr(pipe_pkg::op_li, ra, 0, 0, 16'($random(seed))));
            program_q.push_back(make_instr(pipe_pkg::op_li, rb, 0, 0, 16'($random(seed))));
            program_q.push_back(make_instr(pipe_pkg::op_t'(3'(k)), int'(rand_below(8)),
                                           ra, rb, 16'($random(seed))));
        end
        finish_test();

        // each instruction reads the two results just before it
        start_test("dependent_chain");
        program_q.push_back(make_instr(pipe_pkg::op_li, 1, 0, 0, 16'($random(seed))));
        program_q.push_back(make_instr(pipe_pkg::op_li, 2, 0, 0, 16'($random(seed))));
        prev_1 = 2;
        prev_2 = 1;
        for (int k = 0; k < 38; k++)
        begin
            ins = random_instr();
            ins.op = pipe_pkg::op_t'(3'(rand_below(7)));
            ins.src_1_num = 3'(prev_1);
            ins.src_2_num = 3'(prev_2);
            program_q.push_back(ins);
            prev_2 = prev_1;
            prev_1 = int'(ins.dst_num);
        end
        finish_test();

        start_test("latency");
        check_latency = 1'b1;
        for (int k = 0; k < 50; k++)
            program_q.push_back(random_instr());
        finish_test();
        check_latency = 1'b0;

        start_test("random_flow");
        gap_pct   = 30;
        ready_pct = 60;
        for (int k = 0; k < 300; k++)
            program_q.push_back(random_instr());
        finish_test();
        ready_pct = 100;

        $display("%0d tests, %0d results checked, %0d errors", tests_run, total_checks,
                 total_errors);
        if (total_errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/pipe_core.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_core
#(
    parameter int num_regs = 8
)
(
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               in_valid,
    output logic                               in_ready,
    input  pipe_pkg::op_t                      in_op,
    input  logic [pipe_pkg::reg_num_width-1:0] in_dst_num,
    input  logic [pipe_pkg::reg_num_width-1:0] in_src_1_num,
    input  logic [pipe_pkg::reg_num_width-1:0] in_src_2_num,
    input  logic [pipe_pkg::data_width-1:0]    in_imm,
    output logic                               out_valid,
    input  logic                               out_ready,
    output logic [pipe_pkg::reg_num_width-1:0] out_dst_num,
    output logic [pipe_pkg::data_width-1:0]    out_result
);

    logic [pipe_pkg::data_width-1:0] src_1_value;
    logic [pipe_pkg::data_width-1:0] src_2_value;
    pipe_pkg::de_payload_t           de_in;
    pipe_pkg::de_payload_t           de_out;
    logic                            de_valid;
    logic                            ew_ready;
    pipe_pkg::ew_payload_t           ew_in;
    pipe_pkg::ew_payload_t           ew_out;

    // registers are read as the instruction enters decode
    register_file #(.num_regs(num_regs)) u_regs
    (
        .clk        (clk),
        .reset      (reset),
        .rd_num_1   (in_src_1_num),
        .rd_num_2   (in_src_2_num),
        .rd_value_1 (src_1_value),
        .rd_value_2 (src_2_value),
        .wr_en      (out_valid && out_ready),
        .wr_num     (ew_out.dst_num),
        .wr_value   (ew_out.result)
    );

    always_comb
    begin
        de_in.op          = in_op;
        de_in.dst_num     = in_dst_num;
        de_in.src_1_num   = in_src_1_num;
        de_in.src_1_value = src_1_value;
        de_in.src_2_num   = in_src_2_num;
        de_in.src_2_value = src_2_value;
        de_in.imm         = in_imm;
    end

    stage_register #(.payload_t(pipe_pkg::de_payload_t)) u_de_reg
    (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_payload  (de_in),
        .out_valid   (de_valid),
        .out_ready   (ew_ready),
        .out_payload (de_out)
    );

    execute_stage u_exec
    (
        .de_payload  (de_out),
        .fwd_valid   (out_valid),
        .fwd_payload (ew_out),
        .ew_payload  (ew_in)
    );

    stage_register #(.payload_t(pipe_pkg::ew_payload_t)) u_ew_reg
    (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (de_valid),
        .in_ready    (ew_ready),
        .in_payload  (ew_in),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_payload (ew_out)
    );

    assign out_dst_num = ew_out.dst_num;
    assign out_result  = ew_out.result;

endmodule

`default_nettype wire

// File: verilog/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage
(
    input  pipe_pkg::de_payload_t de_payload,
    input  logic                  fwd_valid,
    input  pipe_pkg::ew_payload_t fwd_payload,
    output pipe_pkg::ew_payload_t ew_payload
);

    logic [pipe_pkg::data_width-1:0] src_1;
    logic [pipe_pkg::data_width-1:0] src_2;
    logic [3:0]                      shift_amount;
    logic                            fwd_1;
    logic                            fwd_2;

    // result sitting in writeback is newer than what decode read
    assign fwd_1 = fwd_valid && fwd_payload.dst_num == de_payload.src_1_num;
    assign fwd_2 = fwd_valid && fwd_payload.dst_num == de_payload.src_2_num;

    always_comb
    begin
        src_1 = de_payload.src_1_value;
        if (fwd_1)
            src_1 = fwd_payload.result;
        src_2 = de_payload.src_2_value;
        if (fwd_2)
            src_2 = fwd_payload.result;
    end

    assign shift_amount = src_2[3:0];

    always_comb
    begin
        ew_payload.dst_num = de_payload.dst_num;
        case (de_payload.op)
            pipe_pkg::op_add:
                ew_payload.result = src_1 + src_2;
            pipe_pkg::op_sub:
                ew_payload.result = src_1 - src_2;
            pipe_pkg::op_and:
                ew_payload.result = src_1 & src_2;
            pipe_pkg::op_or:
                ew_payload.result = src_1 | src_2;
            pipe_pkg::op_xor:
                ew_payload.result = src_1 ^ src_2;
            pipe_pkg::op_shl:
                ew_payload.result = src_1 << shift_amount;
            // logical, zeros shifted in
            pipe_pkg::op_shr:
                ew_payload.result = src_1 >> shift_amount;
            pipe_pkg::op_li:
                ew_payload.result = de_payload.imm;
            default:
                ew_payload.result = '0;
        endcase
    end

    // once a real instruction sits here its opcode must decode
    always_comb
    begin
        if (!$isunknown(de_payload.dst_num))
        begin
            assert (!$isunknown(de_payload.op))
                else $error("undecodable opcode for destination %0d", de_payload.dst_num);
        end
    end

endmodule

`default_nettype wire

// File: verilog/stage_register.sv
`timescale 1ns/10ps
`default_nettype none

module stage_register
#(
    parameter type payload_t = logic
)
(
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_payload,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_payload
);

    logic     valid_q;
    payload_t payload_q;

    // take a new entry when empty or when the current one leaves now
    assign in_ready = !valid_q || out_ready;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            valid_q <= 1'b0;
        end
        else if (in_valid && in_ready)
        begin
            valid_q <= 1'b1;
        end
        else if (out_ready)
        begin
            valid_q <= 1'b0;
        end
    end

    // data only moves on an accepted transfer
    always_ff @(posedge clk)
    begin
        if (in_valid && in_ready)
            payload_q <= in_payload;
    end

    assign out_valid   = valid_q;
    assign out_payload = payload_q;

    // a stalled entry stays put until the next stage takes it
    hold_under_stall: assert property (@(posedge clk) disable iff (!reset)
        out_valid && !out_ready |=> out_valid && $stable(out_payload))
        else $error("stage payload changed while stalled");

endmodule

`default_nettype wire

// File: verilog/register_file.sv
`timescale 1ns/10ps
`default_nettype none

module register_file
#(
    parameter int num_regs = 8
)
(
    input  logic                               clk,
    input  logic                               reset,
    input  logic [pipe_pkg::reg_num_width-1:0] rd_num_1,
    input  logic [pipe_pkg::reg_num_width-1:0] rd_num_2,
    output logic [pipe_pkg::data_width-1:0]    rd_value_1,
    output logic [pipe_pkg::data_width-1:0]    rd_value_2,
    input  logic                               wr_en,
    input  logic [pipe_pkg::reg_num_width-1:0] wr_num,
    input  logic [pipe_pkg::data_width-1:0]    wr_value
);

    logic [pipe_pkg::data_width-1:0] regs [num_regs];

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            for (int i = 0; i < num_regs; i++)
                regs[i] <= '0;
        end
        else if (wr_en)
        begin
            regs[wr_num] <= wr_value;
        end
    end

    // write-through, a result retiring this cycle is visible to decode
    always_comb
    begin
        rd_value_1 = regs[rd_num_1];
        if (wr_en && wr_num == rd_num_1)
            rd_value_1 = wr_value;
        rd_value_2 = regs[rd_num_2];
        if (wr_en && wr_num == rd_num_2)
            rd_value_2 = wr_value;
    end

    wr_num_in_range: assert property (@(posedge clk) disable iff (!reset)
        wr_en |-> wr_num < num_regs)
        else $error("register write to %0d, only %0d registers", wr_num, num_regs);

endmodule

`default_nettype wire

// File: verilog/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    // register data and immediates
    localparam int data_width = 16;
    // enough for eight architectural registers
    localparam int reg_num_width = 3;

    typedef enum logic [2:0]
    {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        // shift amount from low four bits of source two
        op_shl = 3'd5,
        op_shr = 3'd6,
        op_li  = 3'd7
    } op_t;

    // decode to execute, 60 bits
    typedef struct packed
    {
        op_t                      op;
        logic [reg_num_width-1:0] dst_num;
        logic [reg_num_width-1:0] src_1_num;
        logic [data_width-1:0]    src_1_value;
        logic [reg_num_width-1:0] src_2_num;
        logic [data_width-1:0]    src_2_value;
        logic [data_width-1:0]    imm;
    } de_payload_t;

    // execute to writeback, 19 bits
    typedef struct packed
    {
        logic [reg_num_width-1:0] dst_num;
        logic [data_width-1:0]    result;
    } ew_payload_t;

endpackage

`default_nettype wire
